// File: analog_stimulus.txt
# all values hex; T name starts a test
# S pin_a pin_b gen_a gen_b ctl_a ctl_b adc_a adc_b dac_a dac_b (checked next cycle)
# P gen_a gen_b ctl_a ctl_b adc_a adc_b (loopback on, checked same cycle)
# W addr data | R addr rdata | L led
T adc
S 8000 7ffc 0000 0000 0000 0000 3fff 0000 1fff 1fff
S 1237 abcf 0000 0000 0000 0000 1b72 350c 1fff 1fff
S 1234 abcc 0000 0000 0000 0000 1b72 350c 1fff 1fff
S 0003 0001 0000 0000 0000 0000 1fff 1fff 1fff 1fff
T dac
S 0000 0000 0100 3fff 0023 3ffe 1fff 1fff 1edc 2002
S 0000 0000 1fff 2000 0001 3fff 1fff 1fff 0000 3fff
S 0000 0000 1000 2000 0ffe 0000 1fff 1fff 0001 3fff
S 0000 0000 0000 3000 0000 3001 1fff 1fff 1fff 3ffe
T hk
R 00000000 0a5a0100
W 00000008 000000a5
L a5
R 00000008 000000a5
R 0000000c 00000000
T loopback
W 00000004 00000001
R 00000004 00000001
P 0100 3fff 0023 3ffe 0123 3ffd
P 1fff 2000 0001 3fff 1fff 2000
W 00000004 00000000
S 8000 7ffc 0000 0000 0000 0000 3fff 0000 1fff 1fff
T unused
R 00500008 00000000
W 00700008 000000ff
L a5
R 00000008 000000a5
R 00700000 00000000
W 00500004 00000001
R 00000004 00000000

// File: tb.f
analog_pkg.sv
adc_frontend.sv
dac_backend.sv
sys_bus_decoder.sv
hk_regs.sv
analog_top.sv
tb_clkgen.sv
tb_top.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_top -f tb.f -o tb_sim
	./obj_dir/tb_sim | tee sim.log
	grep -q -F '*** PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log

// File: tb_top.sv
// analog path testbench
`timescale 1ns/1ns
`default_nettype none

module tb_top
  import analog_pkg::*;
();

  logic                 adc_clk;
  logic                 rst_n;
  logic [ADC_PIN_W-1:0] adc_dat_a;   // pin side
  logic [ADC_PIN_W-1:0] adc_dat_b;
  logic [SAMPLE_W-1:0]  gen_a;       // generator samples
  logic [SAMPLE_W-1:0]  gen_b;
  logic [SAMPLE_W-1:0]  ctl_a;       // controller samples
  logic [SAMPLE_W-1:0]  ctl_b;
  logic [SYS_AW-1:0]    sys_addr;
  logic [SYS_DW-1:0]    sys_wdata;
  logic                 sys_wen;
  logic                 sys_ren;
  logic [SAMPLE_W-1:0]  adc_a;       // dut outputs, kept unsigned here
  logic [SAMPLE_W-1:0]  adc_b;
  logic [SAMPLE_W-1:0]  dac_a;
  logic [SAMPLE_W-1:0]  dac_b;
  logic [SYS_DW-1:0]    sys_rdata;
  logic                 sys_ack;
  logic                 sys_err;
  logic [LED_W-1:0]     led;

  string cur_test;      // name of the running test
  logic  test_open;
  int    test_errs;
  int    tests_run;
  int    tests_failed;
  int    total_errs;
  int    seed;          // $random state

  tb_clkgen u_clk (
    .clk_o   (adc_clk),
    .rst_n_o (rst_n)
  );

  analog_top u_dut (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n),
    .adc_dat_a_i (adc_dat_a),
    .adc_dat_b_i (adc_dat_b),
    .gen_a_i     (gen_a),
    .gen_b_i     (gen_b),
    .ctl_a_i     (ctl_a),
    .ctl_b_i     (ctl_b),
    .sys_addr_i  (sys_addr),
    .sys_wdata_i (sys_wdata),
    .sys_wen_i   (sys_wen),
    .sys_ren_i   (sys_ren),
    .adc_a_o     (adc_a),
    .adc_b_o     (adc_b),
    .dac_dat_a_o (dac_a),
    .dac_dat_b_o (dac_b),
    .sys_rdata_o (sys_rdata),
    .sys_ack_o   (sys_ack),
    .sys_err_o   (sys_err),
    .led_o       (led)
  );

  //////////////////////////////////////////////////
  // reference model and bookkeeping
  //////////////////////////////////////////////////

  // clamp gen + ctl to the 14 bit range, then flip all but the msb
  function automatic logic [SAMPLE_W-1:0] expected_dac_code(input logic [SAMPLE_W-1:0] g,
                                                             input logic [SAMPLE_W-1:0] c);
    int s;
    int t;
    s = {{18{g[13]}}, g};  // sign extend
    t = {{18{c[13]}}, c};
    s = s + t;
    if (s > 8191)
      s = 8191;
    else if (s < -8192)
      s = -8192;
    return s[13:0] ^ 14'h1fff;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act == exp)
    else
    begin
      $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
      test_errs++;
    end
  endtask

  task automatic close_test();
    tests_run++;
    total_errs += test_errs;
    if (test_errs == 0)
      $display("test %-10s ok", cur_test);
    else
    begin
      tests_failed++;
      $display("test %-10s %0d errors", cur_test, test_errs);
    end
    test_open = 1'b0;
  endtask

  task automatic start_test(input string name);
    if (test_open)
      close_test();
    cur_test  = name;
    test_errs = 0;
    test_open = 1'b1;
  endtask

  //////////////////////////////////////////////////
  // bus master
  //////////////////////////////////////////////////

  // one cycle strobe, wait for ack, one idle cycle after
  // entered and left 2 ns after a rising edge
  task automatic bus_access(input logic is_write, input logic [31:0] addr,
                            input logic [31:0] wdata, input logic [31:0] exp_rd);
    int          lat;
    int          exp_lat;
    logic        got;
    logic        err;
    logic [31:0] rd;
    exp_lat   = (addr[22:20] == 3'd0) ? 1 : 0;  // housekeeping is registered
    sys_addr  = addr;
    sys_wdata = wdata;
    sys_wen   = is_write;
    sys_ren   = !is_write;
    lat       = 0;
    #1;
    got = sys_ack;  // unused regions answer in the strobe cycle
    rd  = sys_rdata;
    err = sys_err;
    while (!got && lat < 10)
    begin
      @(posedge adc_clk);
      #1;
      lat++;
      got = sys_ack;
      rd  = sys_rdata;
      err = sys_err;
      #1;
      sys_wen = 1'b0;
      sys_ren = 1'b0;
    end
    if (lat == 0)
    begin
      @(posedge adc_clk);
      #2;
      sys_wen = 1'b0;
      sys_ren = 1'b0;
    end
    @(posedge adc_clk);  // let the ack drop
    #2;
    if (!got)
    begin
      $display("%0t bus access to %h got no ack within 10 cycles", $time, addr);
      test_errs++;
    end
    else
    begin
      check_value("sys_ack_o latency", exp_lat, lat);
      check_value("sys_err_o", 32'h0, 32'(err));
      if (!is_write)
        check_value("sys_rdata_o", exp_rd, rd);
    end
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial
  begin
    int              fd;
    int              n;
    int              i;
    string           line;
    logic [7:0]      op;
    logic [8*16-1:0] tname;
    logic [31:0]     f0, f1, f2, f3, f4;
    logic [31:0]     f5, f6, f7, f8, f9;
    logic [31:0]     rnd;
    adc_dat_a    = '0;
    adc_dat_b    = '0;
    gen_a        = '0;
    gen_b        = '0;
    ctl_a        = '0;
    ctl_b        = '0;
    sys_addr     = '0;
    sys_wdata    = '0;
    sys_wen      = 1'b0;
    sys_ren      = 1'b0;
    test_open    = 1'b0;
    tests_run    = 0;
    tests_failed = 0;
    total_errs   = 0;

    start_test("reset");
    n = 0;
    while (rst_n !== 1'b1 && n < 10)
    begin
      @(posedge adc_clk);
      n++;
    end
    #2;
    if (rst_n !== 1'b1)
    begin
      $display("%0t reset never released", $time);
      test_errs++;
    end
    check_value("dac_dat_a_o", 32'(DAC_ZERO_CODE), 32'(dac_a));
    check_value("dac_dat_b_o", 32'(DAC_ZERO_CODE), 32'(dac_b));
    check_value("adc_a_o", 32'h1fff, 32'(adc_a));  // conversion of code 0
    check_value("adc_b_o", 32'h1fff, 32'(adc_b));
    check_value("led_o", 32'h0, 32'(led));
    check_value("sys_ack_o", 32'h0, 32'(sys_ack));
    check_value("sys_err_o", 32'h0, 32'(sys_err));
    close_test();

    fd = $fopen("analog_stimulus.txt", "r");
    if (fd == 0)
    begin
      $display("cannot open analog_stimulus.txt");
      total_errs++;
    end
    else
    begin
      while (!$feof(fd))
      begin
        line = "";
        op   = 8'h00;
        void'($fgets(line, fd));
        n = $sscanf(line, "%c %h %h %h %h %h %h %h %h %h %h", op,
                    f0, f1, f2, f3, f4, f5, f6, f7, f8, f9);
        case (op)
          "T":
          begin
            void'($sscanf(line, "%c %s", op, tname));
            start_test($sformatf("%0s", tname));
          end
          "S":  // samples, checked one cycle later
          begin
            adc_dat_a = f0[15:0];
            adc_dat_b = f1[15:0];
            gen_a     = f2[13:0];
            gen_b     = f3[13:0];
            ctl_a     = f4[13:0];
            ctl_b     = f5[13:0];
            @(posedge adc_clk);
            #1;
            check_value("adc_a_o", f6, 32'(adc_a));
            check_value("adc_b_o", f7, 32'(adc_b));
            check_value("dac_dat_a_o", f8, 32'(dac_a));
            check_value("dac_dat_b_o", f9, 32'(dac_b));
            #1;
          end
          "P":  // loopback, same cycle
          begin
            gen_a = f0[13:0];
            gen_b = f1[13:0];
            ctl_a = f2[13:0];
            ctl_b = f3[13:0];
            #1;
            check_value("adc_a_o", f4, 32'(adc_a));
            check_value("adc_b_o", f5, 32'(adc_b));
            @(posedge adc_clk);
            #2;
          end
          "W": bus_access(1'b1, f0, f1, 32'h0);
          "R": bus_access(1'b0, f0, 32'h0, f1);
          "L": check_value("led_o", f0, 32'(led));
          default: ;  // comment or blank line
        endcase
      end
      $fclose(fd);
    end

    // random sums, loopback is off again by now
    start_test("random");
    seed = 32'h44ba0e5e;
    for (i = 0; i < 100; i++)
    begin
      rnd   = $random(seed);
      gen_a = rnd[13:0];
      gen_b = rnd[27:14];
      rnd   = $random(seed);
      ctl_a = rnd[13:0];
      ctl_b = rnd[27:14];
      @(posedge adc_clk);
      #1;
      check_value("dac_dat_a_o", 32'(expected_dac_code(gen_a, ctl_a)), 32'(dac_a));
      check_value("dac_dat_b_o", 32'(expected_dac_code(gen_b, ctl_b)), 32'(dac_b));
      #1;
    end
    close_test();

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errs);
    if (total_errs == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb_clkgen.sv
// testbench clock and reset
`timescale 1ns/1ns
`default_nettype none

module tb_clkgen (
  output logic clk_o,    // adc_clk, 40 ns period
  output logic rst_n_o   // low for the first 3 edges
);

  initial
  begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;  // half period
  end

  // release just after the third rising edge
  initial
  begin
    rst_n_o = 1'b0;
    repeat (3) @(posedge clk_o);
    #1 rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// File: analog_top.sv
// analog path top level
`timescale 1ns/1ns
`default_nettype none

module analog_top
  import analog_pkg::*;
(
  // clock and reset
  input  wire logic                 adc_clk,
  input  wire logic                 rst_n_i,
  // samples in
  input  wire logic [ADC_PIN_W-1:0] adc_dat_a_i,   // adc pins, ch a
  input  wire logic [ADC_PIN_W-1:0] adc_dat_b_i,   // adc pins, ch b
  input  wire sample_t              gen_a_i,       // generator samples
  input  wire sample_t              gen_b_i,
  input  wire sample_t              ctl_a_i,       // controller samples
  input  wire sample_t              ctl_b_i,
  // system bus
  input  wire logic [SYS_AW-1:0]    sys_addr_i,
  input  wire sys_data_t            sys_wdata_i,
  input  wire logic                 sys_wen_i,
  input  wire logic                 sys_ren_i,
  // outputs
  output sample_t                   adc_a_o,       // conditioned adc
  output sample_t                   adc_b_o,
  output dac_code_t                 dac_dat_a_o,   // dac pins, ch a
  output dac_code_t                 dac_dat_b_o,   // dac pins, ch b
  output sys_data_t                 sys_rdata_o,
  output logic                      sys_ack_o,
  output logic                      sys_err_o,
  output logic [LED_W-1:0]          led_o
);

  //////////////////////////////////////////////////
  // local wires
  //////////////////////////////////////////////////

  sample_t   dac_a;         // clamped sums, loopback source
  sample_t   dac_b;
  logic      digital_loop;  // from housekeeping

  logic      hk_wen;
  logic      hk_ren;
  sys_data_t hk_rdata;
  logic      hk_ack;
  logic      hk_err;

  //////////////////////////////////////////////////
  // data path
  //////////////////////////////////////////////////

  adc_frontend u_adc (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .loop_i      (digital_loop),
    .loop_a_i    (dac_a),         // unregistered, same cycle
    .loop_b_i    (dac_b),
    .adc_a_o     (adc_a_o),
    .adc_b_o     (adc_b_o)
  );

  // back end sees only top inputs, so loopback forms no loop
  dac_backend u_dac (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .gen_a_i     (gen_a_i),
    .gen_b_i     (gen_b_i),
    .ctl_a_i     (ctl_a_i),
    .ctl_b_i     (ctl_b_i),
    .sat_a_o     (dac_a),
    .sat_b_o     (dac_b),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o)
  );

  //////////////////////////////////////////////////
  // control bus
  //////////////////////////////////////////////////

  sys_bus_decoder u_dec (
    .sys_addr_i  (sys_addr_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .hk_rdata_i  (hk_rdata),
    .hk_ack_i    (hk_ack),
    .hk_err_i    (hk_err),
    .hk_wen_o    (hk_wen),
    .hk_ren_o    (hk_ren),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .sys_err_o   (sys_err_o)
  );

  hk_regs u_hk (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .sys_addr_i     (sys_addr_i),
    .sys_wdata_i    (sys_wdata_i),
    .wen_i          (hk_wen),
    .ren_i          (hk_ren),
    .rdata_o        (hk_rdata),
    .ack_o          (hk_ack),
    .err_o          (hk_err),
    .digital_loop_o (digital_loop),
    .led_o          (led_o)
  );

endmodule

`default_nettype wire

// File: hk_regs.sv
// housekeeping registers
`timescale 1ns/1ns
`default_nettype none

module hk_regs
  import analog_pkg::*;
(
  input  wire logic              adc_clk,
  input  wire logic              rst_n_i,
  input  wire logic [SYS_AW-1:0] sys_addr_i,
  input  wire sys_data_t         sys_wdata_i,
  input  wire logic              wen_i,           // region-gated write strobe
  input  wire logic              ren_i,           // region-gated read strobe
  output sys_data_t              rdata_o,
  output logic                   ack_o,
  output logic                   err_o,
  output logic                   digital_loop_o,  // adc takes dac data
  output logic [LED_W-1:0]       led_o
);

  logic [REGION_LSB-1:0] offs;  // offset inside the region

  assign offs = sys_addr_i[REGION_LSB-1:0];

  //////////////////////////////////////////////////
  // control registers
  //////////////////////////////////////////////////

  // whole word writes, no byte lanes
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      digital_loop_o <= 1'b0;
      led_o          <= '0;
    end
    else if (wen_i)
    begin
      case (offs)
        HK_ADDR_LOOP: digital_loop_o <= sys_wdata_i[0];
        HK_ADDR_LED:  led_o          <= sys_wdata_i[LED_W-1:0];
        default:      ;  // id is read only, rest ignored
      endcase
    end
  end

  //////////////////////////////////////////////////
  // bus response
  //////////////////////////////////////////////////

  // one cycle ack for either strobe
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
      ack_o <= 1'b0;
    else
      ack_o <= wen_i | ren_i;
  end

  // read data only updated on a read
  always_ff @(posedge adc_clk)
  begin
    if (ren_i)
    begin
      case (offs)
        HK_ADDR_ID:   rdata_o <= HK_ID_VALUE;
        HK_ADDR_LOOP: rdata_o <= {{(SYS_DW-1){1'b0}}, digital_loop_o};
        HK_ADDR_LED:  rdata_o <= {{(SYS_DW-LED_W){1'b0}}, led_o};
        default:      rdata_o <= '0;  // hole in the map
      endcase
    end
  end

  assign err_o = 1'b0;  // every offset is legal

endmodule

`default_nettype wire

// File: sys_bus_decoder.sv
// system bus region decoder
`timescale 1ns/1ns
`default_nettype none

module sys_bus_decoder
  import analog_pkg::*;
(
  input  wire logic [SYS_AW-1:0] sys_addr_i,
  input  wire logic              sys_wen_i,    // master write strobe
  input  wire logic              sys_ren_i,    // master read strobe
  input  wire sys_data_t         hk_rdata_i,   // housekeeping answer
  input  wire logic              hk_ack_i,
  input  wire logic              hk_err_i,
  output logic                   hk_wen_o,     // strobes gated into region 0
  output logic                   hk_ren_o,
  output sys_data_t              sys_rdata_o,  // back to the master
  output logic                   sys_ack_o,
  output logic                   sys_err_o
);

  logic [REGION_MSB-REGION_LSB:0] region;   // region index from addr
  logic [N_REGIONS-1:0]           sys_cs;   // one-hot region select
  logic                           strobe;   // any access this cycle
  sys_data_t                      rdata_arr [N_REGIONS];
  logic [N_REGIONS-1:0]           ack_vec;
  logic [N_REGIONS-1:0]           err_vec;

  //////////////////////////////////////////////////
  // region select
  //////////////////////////////////////////////////

  assign region = sys_addr_i[REGION_MSB:REGION_LSB];
  assign sys_cs = {{(N_REGIONS-1){1'b0}}, 1'b1} << region;
  assign strobe = sys_wen_i | sys_ren_i;

  assign hk_wen_o = sys_cs[HK_REGION] & sys_wen_i;
  assign hk_ren_o = sys_cs[HK_REGION] & sys_ren_i;

  //////////////////////////////////////////////////
  // slave responses
  //////////////////////////////////////////////////

  // unused regions answer right away with zero data
  always_comb
  begin
    for (int i = 0; i < N_REGIONS; i++)
    begin
      if (i == HK_REGION)
      begin
        rdata_arr[i] = hk_rdata_i;
        ack_vec[i]   = hk_ack_i;
        err_vec[i]   = hk_err_i;
      end
      else
      begin
        rdata_arr[i] = '0;
        ack_vec[i]   = strobe;  // same cycle ack
        err_vec[i]   = 1'b0;    // never an error
      end
    end
  end

  //////////////////////////////////////////////////
  // return mux
  //////////////////////////////////////////////////

  // master holds the address until ack, so region stays valid
  assign sys_rdata_o = rdata_arr[region];
  assign sys_ack_o   = |(sys_cs & ack_vec);
  assign sys_err_o   = |(sys_cs & err_vec);

endmodule

`default_nettype wire

// File: dac_backend.sv
// DAC output back end
`timescale 1ns/1ns
`default_nettype none

module dac_backend
  import analog_pkg::*;
(
  input  wire logic    adc_clk,
  input  wire logic    rst_n_i,
  input  wire sample_t gen_a_i,      // generator, ch a
  input  wire sample_t gen_b_i,      // generator, ch b
  input  wire sample_t ctl_a_i,      // controller, ch a
  input  wire sample_t ctl_b_i,      // controller, ch b
  output sample_t      sat_a_o,      // clamped sum, unregistered
  output sample_t      sat_b_o,
  output dac_code_t    dac_dat_a_o,  // registered dac code
  output dac_code_t    dac_dat_b_o
);

  logic [SUM_W-1:0] sum_a;
  logic [SUM_W-1:0] sum_b;

  // clamp a 15 bit sum into the 14 bit range
  // top two bits differ means overflow, sign tells which way
  function automatic sample_t saturate(input logic [SUM_W-1:0] sum);
    if (sum[SUM_W-1] != sum[SUM_W-2])
      return {sum[SUM_W-1], {(SAMPLE_W-1){~sum[SUM_W-1]}}};
    else
      return sum[SAMPLE_W-1:0];
  endfunction

  // two's complement to neg-slope unsigned
  function automatic dac_code_t to_code(input sample_t s);
    return {s[SAMPLE_W-1], ~s[SAMPLE_W-2:0]};
  endfunction

  //////////////////////////////////////////////////
  // sum and saturation
  //////////////////////////////////////////////////

  // sign extend by one bit before adding
  assign sum_a = {gen_a_i[SAMPLE_W-1], gen_a_i} + {ctl_a_i[SAMPLE_W-1], ctl_a_i};
  assign sum_b = {gen_b_i[SAMPLE_W-1], gen_b_i} + {ctl_b_i[SAMPLE_W-1], ctl_b_i};

  assign sat_a_o = saturate(sum_a);  // also feeds adc loopback
  assign sat_b_o = saturate(sum_b);

  //////////////////////////////////////////////////
  // output registers
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      dac_dat_a_o <= DAC_ZERO_CODE;  // mid scale, 0 V out
      dac_dat_b_o <= DAC_ZERO_CODE;
    end
    else
    begin
      dac_dat_a_o <= to_code(sat_a_o);
      dac_dat_b_o <= to_code(sat_b_o);
    end
  end

endmodule

`default_nettype wire

// File: adc_frontend.sv
// ADC input front end
`timescale 1ns/1ns
`default_nettype none

module adc_frontend
  import analog_pkg::*;
(
  input  wire logic                 adc_clk,
  input  wire logic                 rst_n_i,
  input  wire logic [ADC_PIN_W-1:0] adc_dat_a_i,  // ch a pins
  input  wire logic [ADC_PIN_W-1:0] adc_dat_b_i,  // ch b pins
  input  wire logic                 loop_i,       // digital loopback on
  input  wire sample_t              loop_a_i,     // dac side sample, ch a
  input  wire sample_t              loop_b_i,     // dac side sample, ch b
  output sample_t                   adc_a_o,
  output sample_t                   adc_b_o
);

  // raw adc codes straight from the pins
  logic [SAMPLE_W-1:0] adc_q_a;
  logic [SAMPLE_W-1:0] adc_q_b;

  // neg-slope unsigned to two's complement
  // msb stays, the rest flips
  function automatic sample_t to_sample(input logic [SAMPLE_W-1:0] code);
    return {code[SAMPLE_W-1], ~code[SAMPLE_W-2:0]};
  endfunction

  //////////////////////////////////////////////////
  // input registers
  //////////////////////////////////////////////////

  // only the upper 14 pins carry data
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      adc_q_a <= '0;
      adc_q_b <= '0;
    end
    else
    begin
      adc_q_a <= adc_dat_a_i[ADC_PIN_W-1:ADC_LSB_SKIP];  // drop low pins
      adc_q_b <= adc_dat_b_i[ADC_PIN_W-1:ADC_LSB_SKIP];
    end
  end

  //////////////////////////////////////////////////
  // conversion and loopback select
  //////////////////////////////////////////////////

  // loopback path is zero latency, no register in between
  assign adc_a_o = loop_i ? loop_a_i : to_sample(adc_q_a);
  assign adc_b_o = loop_i ? loop_b_i : to_sample(adc_q_b);

endmodule

`default_nettype wire

// File: analog_pkg.sv
// analog data path package
`default_nettype none

package analog_pkg;

  //////////////////////////////////////////////////
  // sample widths
  //////////////////////////////////////////////////

  localparam int ADC_PIN_W    = 16;  // adc pin bus per channel
  localparam int ADC_LSB_SKIP = 2;   // low pins reserved, ignored
  localparam int SAMPLE_W     = 14;  // converted sample
  localparam int SUM_W        = 15;  // gen + ctl, one guard bit

  // two's complement sample as seen by the rest of the design
  typedef logic signed [SAMPLE_W-1:0] sample_t;

  // raw dac code, unsigned with negative slope
  typedef logic [SAMPLE_W-1:0] dac_code_t;

  // code for sample zero: msb low, rest high
  localparam dac_code_t DAC_ZERO_CODE = {1'b0, {(SAMPLE_W-1){1'b1}}};

  //////////////////////////////////////////////////
  // system bus map
  //////////////////////////////////////////////////

  localparam int SYS_AW = 32;
  localparam int SYS_DW = 32;

  typedef logic [SYS_DW-1:0] sys_data_t;

  localparam int REGION_MSB = 22;  // region select bits
  localparam int REGION_LSB = 20;
  localparam int N_REGIONS  = 8;
  localparam int HK_REGION  = 0;   // housekeeping lives here

  // housekeeping offsets, compared below the region bits
  localparam logic [REGION_LSB-1:0] HK_ADDR_ID   = 20'h00000;  // id word, ro
  localparam logic [REGION_LSB-1:0] HK_ADDR_LOOP = 20'h00004;  // digital loopback
  localparam logic [REGION_LSB-1:0] HK_ADDR_LED  = 20'h00008;  // led register

  localparam sys_data_t HK_ID_VALUE = 32'h0A5A_0100;  // board id, read only

  localparam int LED_W = 8;

endpackage

`default_nettype wire
